/* include/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// words of the test program, from address 0
localparam int PROG_LEN = 31;

// response delays in cycles, two bits per entry, picked at random
localparam int          LAT_ENTRIES = 8;
localparam logic [15:0] LAT_PATTERN = 16'b10_00_01_11_00_10_01_00;

function automatic logic [31:0] prog_word(input int idx);
	case (idx)
		// dependent alu chain, each result used by the next word
		0:  return 32'h123450b7;
		1:  return 32'h67808113;
		2:  return 32'h002101b3;
		3:  return 32'h40118233;
		4:  return 32'h002242b3;
		// write to x0, read of x0, then an unknown opcode
		5:  return 32'h00528013;
		6:  return 32'h00100333;
		7:  return 32'hffffffff;
		// three rounds of x8 += 7 counted down in x7
		8:  return 32'h00300393;
		9:  return 32'h00000413;
		10: return 32'h00740413;
		11: return 32'hfff38393;
		12: return 32'hfe039ce3; // bne x7, x0, -8
		// beq not taken, then beq taken over two words
		13: return 32'h00040463;
		14: return 32'h00038663;
		15: return 32'h11100493;
		16: return 32'h22200513;
		// jal x1, +12 with two wrong-path words behind it
		17: return 32'h00c000ef;
		18: return 32'h33300493;
		19: return 32'h44400513;
		20: return 32'h008085b3;
		21: return 32'h00159463; // bne x11, x1, +8
		22: return 32'h55500613;
		23: return 32'h0080006f;
		24: return 32'h66600693;
		// sub from x0, xor, then a branch on a fresh result
		25: return 32'h40800633;
		26: return 32'h007646b3;
		27: return 32'h00000733;
		28: return 32'h00070463;
		29: return 32'h77700793;
		30: return 32'h00168793;
		default: return 32'h0000_0000;
	endcase
endfunction

`endif

/* testbench/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;

	`include "tb_program.svh"

	localparam int MAX_RET = 64;

	logic        clock;
	logic        arst_n_i;
	logic        inst_psel_o;
	logic [31:0] inst_paddr_o;
	logic        inst_pvalid_i;
	logic [31:0] inst_rdata_i;
	logic        retire_valid_o;
	logic        retire_ready_i;
	logic [31:0] retire_pc_o;
	logic [4:0]  retire_rd_o;
	logic [31:0] retire_data_o;

	// expected retirements in program order
	logic [31:0] exp_pc [MAX_RET];
	logic [4:0]  exp_rd [MAX_RET];
	logic [31:0] exp_data [MAX_RET];
	int          exp_count;
	int          ret_idx = 0;
	int          cycle_count = 0;
	logic        out_of_reset = 1'b0;
	logic        fetch_seen = 1'b0;
	logic        mem_busy = 1'b0;
	int          lat_left = 0;
	int          stretch_left = 0;
	logic        retire_fire;
	logic [31:0] head_pc;
	logic [4:0]  head_rd;
	logic [31:0] head_data;
	logic [31:0] prev_paddr;
	logic [31:0] prev_pc;
	logic [4:0]  prev_rd;
	logic [31:0] prev_data;

	cpu_core i_cpu_core (
		.clock          (clock),
		.arst_n_i       (arst_n_i),
		.inst_psel_o    (inst_psel_o),
		.inst_paddr_o   (inst_paddr_o),
		.inst_pvalid_i  (inst_pvalid_i),
		.inst_rdata_i   (inst_rdata_i),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_pc_o    (retire_pc_o),
		.retire_rd_o    (retire_rd_o),
		.retire_data_o  (retire_data_o)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] expected);
		abort_run($sformatf("FAIL %s got 0x%08h expected 0x%08h", sig, got, expected));
	endtask

	// outside the program a no-op that follows every address bit
	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (int'(addr[31:2]) < PROG_LEN) begin
			return prog_word(int'(addr[31:2]));
		end
		return {addr[31:7] ^ addr[24:0], 7'b0001011};
	endfunction

	// runs the program by the isa rules and records each retirement
	task automatic build_expected();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] next_pc;
		logic        wr;
		logic        keep;
		pc = cpu_pkg::RESET_PC;
		exp_count = 0;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		while (int'(pc[31:2]) < PROG_LEN && exp_count < MAX_RET - 1) begin
			inst    = prog_word(int'(pc[31:2]));
			a       = regs[inst[19:15]];
			b       = regs[inst[24:20]];
			res     = '0;
			wr      = 1'b0;
			next_pc = pc + 32'd4;
			case (inst[6:0])
				cpu_pkg::OPC_LUI: begin
					wr  = 1'b1;
					res = {inst[31:12], 12'h000};
				end
				cpu_pkg::OPC_OPIMM: begin
					wr  = inst[14:12] == cpu_pkg::F3_ADD_SUB;
					res = a + 32'($signed(inst[31:20]));
				end
				cpu_pkg::OPC_OP: begin
					if (inst[14:12] == cpu_pkg::F3_ADD_SUB) begin
						wr  = 1'b1;
						res = inst[30] ? a - b : a + b;
					end else if (inst[14:12] == cpu_pkg::F3_XOR) begin
						wr  = 1'b1;
						res = a ^ b;
					end
				end
				cpu_pkg::OPC_BRANCH: begin
					if ((inst[14:12] == cpu_pkg::F3_BEQ && a == b) ||
						(inst[14:12] == cpu_pkg::F3_BNE && a != b)) begin
						next_pc = pc + 32'($signed({inst[31], inst[7], inst[30:25],
							inst[11:8], 1'b0}));
					end
				end
				cpu_pkg::OPC_JAL: begin
					wr      = 1'b1;
					res     = pc + 32'd4;
					next_pc = pc + 32'($signed({inst[31], inst[19:12], inst[20],
						inst[30:21], 1'b0}));
				end
				default: begin
				end
			endcase
			keep = wr && inst[11:7] != '0;
			exp_pc[exp_count]   = pc;
			exp_rd[exp_count]   = keep ? inst[11:7] : 5'd0;
			exp_data[exp_count] = keep ? res : 32'd0;
			if (keep) begin
				regs[inst[11:7]] = res;
			end
			exp_count++;
			pc = next_pc;
		end
	endtask

	task automatic drive_memory();
		int pick;
		inst_pvalid_i = 1'b0;
		if (inst_psel_o) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				pick     = int'($urandom % LAT_ENTRIES);
				lat_left = int'(LAT_PATTERN[2 * pick +: 2]);
			end
			if (lat_left == 0) begin
				inst_pvalid_i = 1'b1;
				inst_rdata_i  = mem_read(inst_paddr_o);
				mem_busy      = 1'b0;
			end else begin
				lat_left--;
			end
		end
	endtask

	// ready low about a third of the time, in stretches of 1 to 4 cycles
	task automatic drive_ready();
		if (stretch_left == 0) begin
			retire_ready_i = ($urandom % 3) != 0;
			stretch_left   = 1 + int'($urandom % 4);
		end
		stretch_left--;
	endtask

	always #20 clock = ~clock;

	initial begin
		void'($urandom(53027));
		clock          = 1'b0;
		arst_n_i       = 1'b0;
		inst_pvalid_i  = 1'b0;
		inst_rdata_i   = '0;
		retire_ready_i = 1'b0;
		build_expected();
		repeat (5) @(negedge clock);
		arst_n_i = 1'b1;
	end

	always @(negedge clock) begin
		if (out_of_reset) begin
			drive_memory();
			drive_ready();
		end
	end

	assign retire_fire = retire_valid_o & retire_ready_i;
	assign head_pc     = exp_pc[ret_idx];
	assign head_rd     = exp_rd[ret_idx];
	assign head_data   = exp_data[ret_idx];

	always @(posedge clock) begin
		cycle_count  <= cycle_count + 1;
		out_of_reset <= arst_n_i;
		prev_paddr   <= inst_paddr_o;
		prev_pc      <= retire_pc_o;
		prev_rd      <= retire_rd_o;
		prev_data    <= retire_data_o;
		if (inst_psel_o && inst_pvalid_i) begin
			fetch_seen <= 1'b1;
		end
		if (retire_fire) begin
			ret_idx <= ret_idx + 1;
		end
	end

	always @(negedge clock) begin
		if (exp_count > 0 && ret_idx == exp_count) begin
			$display("All tests passed!");
			$finish;
		end else if (cycle_count >= 40 * exp_count) begin
			abort_run($sformatf("timeout after %0d cycles, %0d of %0d instructions retired",
				cycle_count, ret_idx, exp_count));
		end
	end

	quiet_in_reset: assert property (@(posedge clock)
		!arst_n_i && cycle_count > 1 |-> !inst_psel_o && !retire_valid_o)
		else abort_run("instruction request or retirement while reset is held");
	first_req: assert property (@(posedge clock) $rose(arst_n_i) |=> inst_psel_o)
		else abort_run("no instruction request in the first cycle after reset");
	first_addr: assert property (@(posedge clock)
		$rose(arst_n_i) |=> inst_paddr_o == cpu_pkg::RESET_PC)
		else report_mismatch("inst_paddr_o", $sampled(inst_paddr_o), cpu_pkg::RESET_PC);
	no_early_retire: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o |-> fetch_seen)
		else abort_run("retirement before any instruction was fetched");

	// every retirement against the head of the expected sequence
	ret_pc_ok: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_fire |-> retire_pc_o == head_pc)
		else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(head_pc));
	ret_rd_ok: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_fire |-> retire_rd_o == head_rd)
		else report_mismatch("retire_rd_o", 32'($sampled(retire_rd_o)),
			32'($sampled(head_rd)));
	ret_data_ok: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_fire |-> retire_data_o == head_data)
		else report_mismatch("retire_data_o", $sampled(retire_data_o), $sampled(head_data));

	// back-pressure on the retire port
	ret_valid_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o && !retire_ready_i |=> retire_valid_o)
		else abort_run("retire_valid_o dropped while retire_ready_i was low");
	ret_pc_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o && !retire_ready_i |=> retire_pc_o == prev_pc)
		else report_mismatch("retire_pc_o", $sampled(retire_pc_o), $sampled(prev_pc));
	ret_rd_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o && !retire_ready_i |=> retire_rd_o == prev_rd)
		else report_mismatch("retire_rd_o", 32'($sampled(retire_rd_o)),
			32'($sampled(prev_rd)));
	ret_data_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o && !retire_ready_i |=> retire_data_o == prev_data)
		else report_mismatch("retire_data_o", $sampled(retire_data_o), $sampled(prev_data));

	// open instruction request
	req_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		inst_psel_o && !inst_pvalid_i |=> inst_psel_o)
		else abort_run("inst_psel_o dropped before inst_pvalid_i answered");
	addr_held: assert property (@(posedge clock) disable iff (!arst_n_i)
		inst_psel_o && !inst_pvalid_i |=> inst_paddr_o == prev_paddr)
		else report_mismatch("inst_paddr_o", $sampled(inst_paddr_o), $sampled(prev_paddr));

endmodule

/* verilog.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/stage_bus_if.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/exec_stage.sv
verilog/wb_stage.sv
verilog/cpu_core.sv
testbench/tb_cpu_core.sv

/* verilog/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
	input  logic                           clock,
	input  logic                           arst_n_i,
	output logic                           inst_psel_o,
	output logic [cpu_pkg::XLEN-1:0]       inst_paddr_o,
	input  logic                           inst_pvalid_i,
	input  logic [cpu_pkg::XLEN-1:0]       inst_rdata_i,
	output logic                           retire_valid_o,
	input  logic                           retire_ready_i,
	output logic [cpu_pkg::XLEN-1:0]       retire_pc_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] retire_rd_o,
	output logic [cpu_pkg::XLEN-1:0]       retire_data_o
);

	logic                           redirect;
	logic [cpu_pkg::XLEN-1:0]       redirect_pc;
	logic                           wb_wen;
	logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd;
	logic [cpu_pkg::XLEN-1:0]       wb_data;

	stage_bus_if #(.payload_t(cpu_pkg::fs_to_es_t)) fs_es ();
	stage_bus_if #(.payload_t(cpu_pkg::es_to_ws_t)) es_ws ();

	fetch_stage i_fetch_stage (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.inst_psel_o   (inst_psel_o),
		.inst_paddr_o  (inst_paddr_o),
		.inst_pvalid_i (inst_pvalid_i),
		.inst_rdata_i  (inst_rdata_i),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.fs_es         (fs_es.src)
	);

	exec_stage i_exec_stage (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.fs_es         (fs_es.dst),
		.es_ws         (es_ws.src),
		.wb_wen_i      (wb_wen),
		.wb_rd_i       (wb_rd),
		.wb_data_i     (wb_data),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc)
	);

	wb_stage i_wb_stage (
		.clock          (clock),
		.arst_n_i       (arst_n_i),
		.es_ws          (es_ws.dst),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_pc_o    (retire_pc_o),
		.retire_rd_o    (retire_rd_o),
		.retire_data_o  (retire_data_o),
		.wb_wen_o       (wb_wen),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data)
	);

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

	// datapath and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// rv32i major opcodes in use
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	// funct3 encodings
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	// fetch to execute
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] inst;
	} fs_to_es_t;

	// execute to writeback
	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       result;
	} es_to_ws_t;

endpackage

/* verilog/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
	input  logic                           clock,
	input  logic                           arst_n_i,
	stage_bus_if.dst                       fs_es,
	stage_bus_if.src                       es_ws,
	input  logic                           wb_wen_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  logic [cpu_pkg::XLEN-1:0]       wb_data_i,
	output logic                           redirect_o,
	output logic [cpu_pkg::XLEN-1:0]       redirect_pc_o
);

	logic                           es_valid_q;
	cpu_pkg::fs_to_es_t             es_q;
	logic [6:0]                     opcode;
	logic [2:0]                     funct3;
	logic [cpu_pkg::REG_ADDR_W-1:0] rd;
	logic [cpu_pkg::REG_ADDR_W-1:0] rs1;
	logic [cpu_pkg::REG_ADDR_W-1:0] rs2;
	logic [cpu_pkg::XLEN-1:0]       imm_i;
	logic [cpu_pkg::XLEN-1:0]       imm_u;
	logic [cpu_pkg::XLEN-1:0]       imm_b;
	logic [cpu_pkg::XLEN-1:0]       imm_j;
	logic [cpu_pkg::XLEN-1:0]       rdata1;
	logic [cpu_pkg::XLEN-1:0]       rdata2;
	logic [cpu_pkg::XLEN-1:0]       op1;
	logic [cpu_pkg::XLEN-1:0]       op2;
	logic [cpu_pkg::XLEN-1:0]       result;
	logic [cpu_pkg::XLEN-1:0]       target;
	logic                           wen;
	logic                           taken;
	logic                           fire_out;

	assign opcode = es_q.inst[6:0];
	assign rd     = es_q.inst[11:7];
	assign funct3 = es_q.inst[14:12];
	assign rs1    = es_q.inst[19:15];
	assign rs2    = es_q.inst[24:20];
	assign imm_i  = {{20{es_q.inst[31]}}, es_q.inst[31:20]};
	assign imm_u  = {es_q.inst[31:12], 12'b0};
	assign imm_b  = {{20{es_q.inst[31]}}, es_q.inst[7], es_q.inst[30:25],
		es_q.inst[11:8], 1'b0};
	assign imm_j  = {{12{es_q.inst[31]}}, es_q.inst[19:12], es_q.inst[20],
		es_q.inst[30:21], 1'b0};

	regfile i_regfile (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wen_i    (wb_wen_i),
		.waddr_i  (wb_rd_i),
		.wdata_i  (wb_data_i)
	);

	// bypass from the instruction retiring this cycle
	assign op1 = (wb_wen_i && wb_rd_i != '0 && wb_rd_i == rs1) ? wb_data_i : rdata1;
	assign op2 = (wb_wen_i && wb_rd_i != '0 && wb_rd_i == rs2) ? wb_data_i : rdata2;

	always_comb begin
		wen    = 1'b0;
		result = '0;
		taken  = 1'b0;
		target = es_q.pc + imm_b;
		case (opcode)
			cpu_pkg::OPC_LUI: begin
				wen    = 1'b1;
				result = imm_u;
			end
			cpu_pkg::OPC_OPIMM: begin
				if (funct3 == cpu_pkg::F3_ADD_SUB) begin
					wen    = 1'b1;
					result = op1 + imm_i;
				end
			end
			cpu_pkg::OPC_OP: begin
				if (funct3 == cpu_pkg::F3_ADD_SUB) begin
					wen    = 1'b1;
					// bit 30 selects sub
					result = es_q.inst[30] ? op1 - op2 : op1 + op2;
				end else if (funct3 == cpu_pkg::F3_XOR) begin
					wen    = 1'b1;
					result = op1 ^ op2;
				end
			end
			cpu_pkg::OPC_BRANCH: begin
				if (funct3 == cpu_pkg::F3_BEQ) begin
					taken = (op1 == op2);
				end else if (funct3 == cpu_pkg::F3_BNE) begin
					taken = (op1 != op2);
				end
			end
			cpu_pkg::OPC_JAL: begin
				wen    = 1'b1;
				result = es_q.pc + 32'd4;
				taken  = 1'b1;
				target = es_q.pc + imm_j;
			end
			default: begin
			end
		endcase
	end

	assign fire_out      = es_valid_q & es_ws.allowin;
	assign redirect_o    = fire_out & taken;
	assign redirect_pc_o = target;
	// the slot behind a taken branch is wrong path, keep it out
	assign fs_es.allowin = (~es_valid_q | es_ws.allowin) & ~redirect_o;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			es_valid_q <= 1'b0;
		end else if (fs_es.valid & fs_es.allowin) begin
			es_valid_q <= 1'b1;
		end else if (fire_out) begin
			es_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (fs_es.valid & fs_es.allowin) begin
			es_q <= fs_es.payload;
		end
	end

	assign es_ws.valid          = es_valid_q;
	assign es_ws.payload.pc     = es_q.pc;
	assign es_ws.payload.wen    = wen;
	assign es_ws.payload.rd     = rd;
	assign es_ws.payload.result = result;

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
	input  logic                     clock,
	input  logic                     arst_n_i,
	output logic                     inst_psel_o,
	output logic [cpu_pkg::XLEN-1:0] inst_paddr_o,
	input  logic                     inst_pvalid_i,
	input  logic [cpu_pkg::XLEN-1:0] inst_rdata_i,
	input  logic                     redirect_i,
	input  logic [cpu_pkg::XLEN-1:0] redirect_pc_i,
	stage_bus_if.src                 fs_es
);

	logic [cpu_pkg::XLEN-1:0] pc_q;
	logic [cpu_pkg::XLEN-1:0] pc_d;
	logic [cpu_pkg::XLEN-1:0] paddr_q;
	logic                     req_q;
	logic                     req_d;
	logic                     req_hold;
	logic                     stale_q;
	logic                     slot_valid_q;
	logic                     slot_valid_d;
	cpu_pkg::fs_to_es_t       slot_q;
	logic                     resp_fire;
	logic                     resp_take;

	assign resp_fire = req_q & inst_pvalid_i;
	// wrong-path data is dropped, also when the redirect lands with it
	assign resp_take = resp_fire & ~stale_q & ~redirect_i;
	assign req_hold  = req_q & ~inst_pvalid_i;

	always_comb begin
		pc_d = pc_q;
		if (redirect_i) begin
			pc_d = redirect_pc_i;
		end else if (resp_take) begin
			pc_d = pc_q + 32'd4;
		end
	end

	always_comb begin
		slot_valid_d = slot_valid_q;
		if (redirect_i) begin
			slot_valid_d = 1'b0;
		end else if (resp_take) begin
			slot_valid_d = 1'b1;
		end else if (fs_es.valid & fs_es.allowin) begin
			slot_valid_d = 1'b0;
		end
	end

	// one request at a time, only into an empty slot
	assign req_d = req_hold | ~slot_valid_d;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q         <= cpu_pkg::RESET_PC;
			req_q        <= 1'b0;
			stale_q      <= 1'b0;
			slot_valid_q <= 1'b0;
		end else begin
			pc_q         <= pc_d;
			req_q        <= req_d;
			slot_valid_q <= slot_valid_d;
			if (resp_fire) begin
				stale_q <= 1'b0;
			end else if (redirect_i & req_q) begin
				stale_q <= 1'b1;
			end
		end
	end

	// address frozen while the request is open
	always_ff @(posedge clock) begin
		if (req_d & ~req_hold) begin
			paddr_q <= pc_d;
		end
		if (resp_take) begin
			slot_q.pc   <= paddr_q;
			slot_q.inst <= inst_rdata_i;
		end
	end

	assign inst_psel_o   = req_q;
	assign inst_paddr_o  = paddr_q;
	assign fs_es.valid   = slot_valid_q;
	assign fs_es.payload = slot_q;

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                           clock,
	input  logic                           arst_n_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
	output logic [cpu_pkg::XLEN-1:0]       rdata1_o,
	output logic [cpu_pkg::XLEN-1:0]       rdata2_o,
	input  logic                           wen_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
	input  logic [cpu_pkg::XLEN-1:0]       wdata_i
);

	logic [cpu_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 is never written so it reads back zero
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

/* verilog/stage_bus_if.sv */
`timescale 1ns/1ps

// valid/allowin handshake between two pipeline stages
interface stage_bus_if #(
	parameter type payload_t = logic
) ();

	logic     valid;
	logic     allowin;
	payload_t payload;

	modport src (
		output valid,
		output payload,
		input  allowin
	);

	modport dst (
		input  valid,
		input  payload,
		output allowin
	);

endinterface

/* verilog/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
	input  logic                           clock,
	input  logic                           arst_n_i,
	stage_bus_if.dst                       es_ws,
	output logic                           retire_valid_o,
	input  logic                           retire_ready_i,
	output logic [cpu_pkg::XLEN-1:0]       retire_pc_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] retire_rd_o,
	output logic [cpu_pkg::XLEN-1:0]       retire_data_o,
	output logic                           wb_wen_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [cpu_pkg::XLEN-1:0]       wb_data_o
);

	logic               ws_valid_q;
	cpu_pkg::es_to_ws_t ws_q;
	logic               commit_wen;

	assign es_ws.allowin = ~ws_valid_q | retire_ready_i;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ws_valid_q <= 1'b0;
		end else if (es_ws.valid & es_ws.allowin) begin
			ws_valid_q <= 1'b1;
		end else if (retire_ready_i) begin
			ws_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (es_ws.valid & es_ws.allowin) begin
			ws_q <= es_ws.payload;
		end
	end

	// no-ops and x0 writes report as rd 0, data 0
	assign commit_wen     = ws_q.wen & (ws_q.rd != '0);
	assign retire_valid_o = ws_valid_q;
	assign retire_pc_o    = ws_q.pc;
	assign retire_rd_o    = commit_wen ? ws_q.rd : '0;
	assign retire_data_o  = commit_wen ? ws_q.result : '0;

	// register write lands on the retire edge
	assign wb_wen_o  = ws_valid_q & retire_ready_i & commit_wen;
	assign wb_rd_o   = ws_q.rd;
	assign wb_data_o = ws_q.result;

endmodule
